// ==== design/barrier_map.sv ====
`timescale 1ns/1ps

module barrier_map (
    input  zombie_arena_pkg::level_t    level_sel,
    output zombie_arena_pkg::wall_map_t walls
);

    // Per-tile wall bit, all shape decisions are constant per tile
    for (genvar r = 0; r < zombie_arena_pkg::map_rows; r++) begin : g_row
        for (genvar c = 0; c < zombie_arena_pkg::map_cols; c++) begin : g_col
            localparam bit is_border = (r == 0) || (r == zombie_arena_pkg::map_rows - 1) ||
                                       (c == 0) || (c == zombie_arena_pkg::map_cols - 1);
            localparam bit in_span = (r >= zombie_arena_pkg::col_top_row) &&
                                     (r <= zombie_arena_pkg::col_bot_row);
            localparam bit on_col1 = in_span && (c == zombie_arena_pkg::lvl1_col);
            localparam bit on_col2 = in_span && (c == zombie_arena_pkg::lvl2_col);

            assign walls[r][c] = is_border ||
                                 (on_col1 && level_sel >= 2'd1) ||   // Level 1 column
                                 (on_col2 && level_sel >= 2'd2);     // Level 2 and 3
        end
    end

endmodule

// ==== design/game_state.sv ====
`timescale 1ns/1ps

module game_state (
    input  logic                     Clk,
    input  logic                     reset,
    input  logic                     play,
    input  logic                     frame_tick,
    input  logic [2:0]               touching,     // One bit per zombie
    output zombie_arena_pkg::phase_t phase,
    output logic [1:0]               health,
    output logic                     round_start
);

    logic hit;

    // Damage on a playing tick, never in the spawn reload cycle
    assign hit = frame_tick && (|touching) && !round_start;

    // ----------------------------------------
    // Phase FSM and health
    always_ff @(posedge Clk) begin
        if (reset) begin
            phase       <= zombie_arena_pkg::ph_idle;
            health      <= zombie_arena_pkg::start_health;
            round_start <= 1'b0;
        end else begin
            round_start <= 1'b0;            // Single cycle pulse
            case (phase)
                zombie_arena_pkg::ph_idle,
                zombie_arena_pkg::ph_lost: begin
                    if (play) begin
                        phase       <= zombie_arena_pkg::ph_playing;
                        round_start <= 1'b1;
                        health      <= zombie_arena_pkg::start_health;
                    end
                end
                zombie_arena_pkg::ph_playing: begin
                    if (hit) begin
                        health <= health - 2'd1;
                        if (health == 2'd1)
                            phase <= zombie_arena_pkg::ph_lost;   // Last hit point gone
                    end
                end
                default: phase <= zombie_arena_pkg::ph_idle;
            endcase
        end
    end

    // Refill only at round start
    a_health_refill: assert property (@(posedge Clk) disable iff (reset)
        (health > $past(health)) |-> round_start)
        else $error("health rose outside round start");

endmodule

// ==== design/keycode_decoder.sv ====
`timescale 1ns/1ps

module keycode_decoder (
    input  logic [7:0]               keycode0,
    input  logic [7:0]               keycode1,
    output zombie_arena_pkg::move_t  move
);

    zombie_arena_pkg::move_t move0; // Candidate from first byte
    zombie_arena_pkg::move_t move1;

    // WASD to direction, anything else is no move
    function automatic zombie_arena_pkg::move_t key_to_move(input logic [7:0] code);
        case (code)
            zombie_arena_pkg::key_w: return zombie_arena_pkg::mv_up;
            zombie_arena_pkg::key_s: return zombie_arena_pkg::mv_down;
            zombie_arena_pkg::key_a: return zombie_arena_pkg::mv_left;
            zombie_arena_pkg::key_d: return zombie_arena_pkg::mv_right;
            default:                 return zombie_arena_pkg::mv_none;
        endcase
    endfunction

    always_comb begin
        move0 = key_to_move(keycode0);
        move1 = key_to_move(keycode1);
        // keycode0 wins when it is a movement key
        if (move0 != zombie_arena_pkg::mv_none)
            move = move0;
        else
            move = move1;           // May still be none
    end

endmodule

// ==== design/shooter_motion.sv ====
`timescale 1ns/1ps

module shooter_motion (
    input  logic                        Clk,
    input  logic                        reset,
    input  logic                        frame_tick,
    input  logic                        round_start,
    input  zombie_arena_pkg::phase_t    phase,
    input  zombie_arena_pkg::move_t     move,
    input  zombie_arena_pkg::wall_map_t walls,
    output zombie_arena_pkg::pos_t      shooter
);

    zombie_arena_pkg::pos_t cand;   // Position one step away
    logic                   step_ok;
    logic                   advance;

    // ----------------------------------------
    // Candidate step
    always_comb begin
        cand = shooter;
        case (move)
            zombie_arena_pkg::mv_up:    cand.y = shooter.y - 10'(zombie_arena_pkg::shooter_step);
            zombie_arena_pkg::mv_down:  cand.y = shooter.y + 10'(zombie_arena_pkg::shooter_step);
            zombie_arena_pkg::mv_left:  cand.x = shooter.x - 10'(zombie_arena_pkg::shooter_step);
            zombie_arena_pkg::mv_right: cand.x = shooter.x + 10'(zombie_arena_pkg::shooter_step);
            default: ;                  // No key, stay put
        endcase
        step_ok = !zombie_arena_pkg::tile_is_wall(walls, cand);  // Floor only
    end

    assign advance = frame_tick && (phase == zombie_arena_pkg::ph_playing);

    // ----------------------------------------
    // Position register
    always_ff @(posedge Clk) begin
        if (reset || round_start) begin         // Back to spawn
            shooter.x <= zombie_arena_pkg::shooter_spawn_x;
            shooter.y <= zombie_arena_pkg::shooter_spawn_y;
        end else if (advance && step_ok) begin
            shooter <= cand;
        end
    end

    // Walls must keep the shooter off the border tiles
    a_inside: assert property (@(posedge Clk) disable iff (reset)
        shooter.x >= 10'(zombie_arena_pkg::tile_px) &&
        shooter.x < 10'((zombie_arena_pkg::map_cols - 1) * zombie_arena_pkg::tile_px) &&
        shooter.y >= 10'(zombie_arena_pkg::tile_px) &&
        shooter.y < 10'((zombie_arena_pkg::map_rows - 1) * zombie_arena_pkg::tile_px))
        else $error("shooter left the inner arena");

endmodule

// ==== design/zombie_arena.sv ====
`timescale 1ns/1ps

module zombie_arena (
    input  logic                                  Clk,
    input  logic                                  reset,
    input  logic                                  play,
    input  logic [7:0]                            keycode0,
    input  logic [7:0]                            keycode1,
    input  logic                                  frame_tick,   // One cycle per frame
    input  zombie_arena_pkg::level_t              level_sel,
    output zombie_arena_pkg::pos_t                shooter,
    output zombie_arena_pkg::zombie_status_t [2:0] zombies,
    output logic [1:0]                            health,
    output zombie_arena_pkg::phase_t              phase
);

    zombie_arena_pkg::move_t     move;
    zombie_arena_pkg::wall_map_t walls;
    logic [2:0]                  touching;
    logic                        round_start;

    // ----------------------------------------
    // Input decode and map
    keycode_decoder keycode_decoder_inst (.keycode0, .keycode1, .move);

    barrier_map barrier_map_inst (.level_sel, .walls);

    // ----------------------------------------
    // Movers
    shooter_motion shooter_motion_inst (
        .Clk, .reset, .frame_tick, .round_start, .phase, .move, .walls, .shooter
    );

    zombie_chaser #(.spawn_x(64), .spawn_y(96), .speed(1), .spawn_delay(1)) zombie_0_inst (
        .Clk, .reset, .frame_tick, .round_start, .phase, .walls, .shooter,
        .status(zombies[0]), .touching(touching[0])
    );

    zombie_chaser #(.spawn_x(544), .spawn_y(96), .speed(4), .spawn_delay(1)) zombie_1_inst (
        .Clk, .reset, .frame_tick, .round_start, .phase, .walls, .shooter,
        .status(zombies[1]), .touching(touching[1])     // Fast one
    );

    zombie_chaser #(.spawn_x(64), .spawn_y(384), .speed(1), .spawn_delay(60)) zombie_2_inst (
        .Clk, .reset, .frame_tick, .round_start, .phase, .walls, .shooter,
        .status(zombies[2]), .touching(touching[2])     // Late spawner
    );

    // ----------------------------------------
    // Phase and health
    game_state game_state_inst (
        .Clk, .reset, .play, .frame_tick, .touching, .phase, .health, .round_start
    );

endmodule

// ==== design/zombie_arena_pkg.sv ====
package zombie_arena_pkg;

    // Arena geometry, in pixels and tiles
    localparam int tile_px      = 32;
    localparam int map_rows     = 15;
    localparam int map_cols     = 20;
    localparam int shooter_step = 4;            // Pixels per frame tick
    localparam int contact_px   = 16;           // Touch distance per axis
    localparam logic [1:0] start_health = 2'd3;

    localparam logic [9:0] shooter_spawn_x = 10'd320;
    localparam logic [9:0] shooter_spawn_y = 10'd224;

    // Inner wall columns added by the level select
    localparam int lvl1_col = 6;
    localparam int lvl2_col = 13;
    localparam int col_top_row = 4;
    localparam int col_bot_row = 10;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } pos_t;

    typedef struct packed {
        pos_t pos;
        logic alive;
    } zombie_status_t;

    typedef logic [map_rows-1:0][map_cols-1:0] wall_map_t;  // [row][col], 1 = wall
    typedef logic [1:0] level_t;

    typedef enum logic [2:0] {mv_none, mv_up, mv_down, mv_left, mv_right} move_t;

    // USB HID usage codes
    typedef enum logic [7:0] {
        key_a = 8'h04,
        key_d = 8'h07,
        key_s = 8'h16,
        key_w = 8'h1A
    } key_code_t;

    typedef enum logic [1:0] {ph_idle, ph_playing, ph_lost} phase_t;

    // Wall lookup for the tile under a point, off-map counts as wall
    function automatic logic tile_is_wall(input wall_map_t w, input pos_t p);
        logic [4:0] row;
        logic [4:0] col;
        row = 5'(p.y / tile_px);
        col = 5'(p.x / tile_px);
        if (row >= map_rows || col >= map_cols) return 1'b1;
        return w[row][col];
    endfunction

endpackage

// ==== design/zombie_chaser.sv ====
`timescale 1ns/1ps

module zombie_chaser #(
    parameter int spawn_x     = 64,
    parameter int spawn_y     = 96,
    parameter int speed       = 1,
    parameter int spawn_delay = 1         // Playing ticks before release
) (
    input  logic                             Clk,
    input  logic                             reset,
    input  logic                             frame_tick,
    input  logic                             round_start,
    input  zombie_arena_pkg::phase_t         phase,
    input  zombie_arena_pkg::wall_map_t      walls,
    input  zombie_arena_pkg::pos_t           shooter,
    output zombie_arena_pkg::zombie_status_t status,
    output logic                             touching
);

    localparam int cnt_w = $clog2(spawn_delay + 1);
    localparam logic [9:0] speed_px = 10'(speed);

    logic [cnt_w-1:0]       spawn_cnt;      // Ticks seen while dead
    logic [9:0]             dx, dy;         // Absolute distances
    logic [9:0]             step_x, step_y;
    logic                   x_first;
    zombie_arena_pkg::pos_t cand_x, cand_y, first, second, next_pos;
    logic                   advance;

    // ----------------------------------------
    // Steering
    always_comb begin
        dx = (shooter.x >= status.pos.x) ? shooter.x - status.pos.x : status.pos.x - shooter.x;
        dy = (shooter.y >= status.pos.y) ? shooter.y - status.pos.y : status.pos.y - shooter.y;
        step_x = (dx < speed_px) ? dx : speed_px;   // Never overshoot
        step_y = (dy < speed_px) ? dy : speed_px;
        x_first = (dx >= dy);                        // Tie goes to x

        cand_x = status.pos;
        cand_x.x = (shooter.x >= status.pos.x) ? status.pos.x + step_x : status.pos.x - step_x;
        cand_y = status.pos;
        cand_y.y = (shooter.y >= status.pos.y) ? status.pos.y + step_y : status.pos.y - step_y;

        first  = x_first ? cand_x : cand_y;
        second = x_first ? cand_y : cand_x;
        if (!zombie_arena_pkg::tile_is_wall(walls, first))
            next_pos = first;
        else if (!zombie_arena_pkg::tile_is_wall(walls, second))
            next_pos = second;      // Slide along the wall
        else
            next_pos = status.pos;  // Boxed in
    end

    assign advance = frame_tick && (phase == zombie_arena_pkg::ph_playing);

    // Contact on current positions, dead zombies never touch
    assign touching = status.alive && (dx < 10'(zombie_arena_pkg::contact_px)) &&
                      (dy < 10'(zombie_arena_pkg::contact_px));

    // ----------------------------------------
    // Spawn counter and position
    always_ff @(posedge Clk) begin
        if (reset || round_start) begin
            status.pos.x <= 10'(spawn_x);
            status.pos.y <= 10'(spawn_y);
            status.alive <= 1'b0;
            spawn_cnt    <= '0;
        end else if (advance) begin
            if (status.alive) begin
                status.pos <= next_pos;
            end else if (spawn_cnt == cnt_w'(spawn_delay - 1)) begin
                status.alive <= 1'b1;               // Released, moves from next tick
            end else begin
                spawn_cnt <= spawn_cnt + 1'b1;
            end
        end
    end

    // Only a new round may kill a live zombie during play
    a_alive_hold: assert property (@(posedge Clk) disable iff (reset)
        (status.alive && phase == zombie_arena_pkg::ph_playing && !round_start)
        |=> (status.alive || phase != zombie_arena_pkg::ph_playing))
        else $error("zombie alive bit fell during play");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f zombie_arena.f --top-module zombie_arena_tb -Mdir obj_dir

./obj_dir/Vzombie_arena_tb | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported failure, see sim.log"
    exit 1
fi
echo "Simulation finished without failure"

// ==== verification/zombie_arena_tb.sv ====
`timescale 1ns/1ps

module zombie_arena_tb;

    localparam int max_cycles = 6000;           // Covers about 1200 frames
    localparam int z_spawn_x [3] = '{64, 544, 64};
    localparam int z_spawn_y [3] = '{96, 96, 384};
    localparam int z_speed [3]   = '{1, 4, 1};
    localparam int z_delay [3]   = '{1, 1, 60};  // Playing ticks before release
    // WASD first, then codes that must not move anything
    localparam logic [7:0] key_pool [8] = '{8'h1A, 8'h04, 8'h16, 8'h07,
                                            8'h00, 8'h2C, 8'h28, 8'hE1};

    logic                                   Clk = 1'b0;
    logic                                   reset;
    logic                                   play;
    logic [7:0]                             keycode0;
    logic [7:0]                             keycode1;
    logic                                   frame_tick;
    zombie_arena_pkg::level_t               level_sel;
    zombie_arena_pkg::pos_t                 shooter;
    zombie_arena_pkg::zombie_status_t [2:0] zombies;
    logic [1:0]                             health;
    zombie_arena_pkg::phase_t               phase;

    // ----------------------------------------
    // Reference model state
    zombie_arena_pkg::pos_t   m_shooter;
    zombie_arena_pkg::pos_t   m_zpos [3];
    logic                     m_alive [3];
    int                       m_cnt [3];     // Spawn ticks seen
    logic [1:0]               m_health;
    zombie_arena_pkg::phase_t m_phase;

    int   n_checks = 0;
    int   n_errors = 0;
    int   err_mark = 0;                      // Errors before current test
    int   cycles = 0;
    event sample_ev;                         // Outputs settled, time to compare
    logic compare_pending = 1'b0;            // High until the compare pass is done

    zombie_arena zombie_arena_inst (
        .Clk, .reset, .play, .keycode0, .keycode1, .frame_tick, .level_sel,
        .shooter, .zombies, .health, .phase
    );

    always #5 Clk = ~Clk;                    // 10 ns period

    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("Timeout after %0d cycles, test sequence did not finish", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // Reference functions
    function automatic logic ref_wall(input int lvl, input logic [9:0] x, input logic [9:0] y);
        int row;
        int col;
        row = int'(y) / zombie_arena_pkg::tile_px;
        col = int'(x) / zombie_arena_pkg::tile_px;
        if (row > 14 || col > 19) return 1'b1;                  // Off the map
        if (row == 0 || row == 14 || col == 0 || col == 19) return 1'b1;
        if (row >= 4 && row <= 10) begin
            if (col == 6 && lvl >= 1) return 1'b1;
            if (col == 13 && lvl >= 2) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic zombie_arena_pkg::move_t key_dir(input logic [7:0] k);
        if (k == 8'h1A) return zombie_arena_pkg::mv_up;
        if (k == 8'h16) return zombie_arena_pkg::mv_down;
        if (k == 8'h04) return zombie_arena_pkg::mv_left;
        if (k == 8'h07) return zombie_arena_pkg::mv_right;
        return zombie_arena_pkg::mv_none;
    endfunction

    function automatic zombie_arena_pkg::move_t ref_move(input logic [7:0] k0,
                                                          input logic [7:0] k1);
        if (key_dir(k0) != zombie_arena_pkg::mv_none) return key_dir(k0);
        return key_dir(k1);                  // Second byte only as fallback
    endfunction

    function automatic zombie_arena_pkg::pos_t ref_shooter_step(input zombie_arena_pkg::pos_t p,
            input zombie_arena_pkg::move_t mv, input int lvl);
        zombie_arena_pkg::pos_t n;
        n = p;
        case (mv)
            zombie_arena_pkg::mv_up:    n.y = p.y - 10'd4;
            zombie_arena_pkg::mv_down:  n.y = p.y + 10'd4;
            zombie_arena_pkg::mv_left:  n.x = p.x - 10'd4;
            zombie_arena_pkg::mv_right: n.x = p.x + 10'd4;
            default: ;
        endcase
        return ref_wall(lvl, n.x, n.y) ? p : n;
    endfunction

    function automatic int absdiff(input logic [9:0] a, input logic [9:0] b);
        return (a >= b) ? int'(a - b) : int'(b - a);
    endfunction

    function automatic zombie_arena_pkg::pos_t ref_chase(input zombie_arena_pkg::pos_t z,
            input zombie_arena_pkg::pos_t s, input int spd, input int lvl);
        zombie_arena_pkg::pos_t by_x;
        zombie_arena_pkg::pos_t by_y;
        int dx;
        int dy;
        dx = absdiff(z.x, s.x);
        dy = absdiff(z.y, s.y);
        by_x = z;
        by_y = z;
        by_x.x = (s.x >= z.x) ? z.x + 10'((dx < spd) ? dx : spd) : z.x - 10'((dx < spd) ? dx : spd);
        by_y.y = (s.y >= z.y) ? z.y + 10'((dy < spd) ? dy : spd) : z.y - 10'((dy < spd) ? dy : spd);
        if (dx >= dy) begin                  // Larger gap first, x on a tie
            if (!ref_wall(lvl, by_x.x, by_x.y)) return by_x;
            if (!ref_wall(lvl, by_y.x, by_y.y)) return by_y;
        end else begin
            if (!ref_wall(lvl, by_y.x, by_y.y)) return by_y;
            if (!ref_wall(lvl, by_x.x, by_x.y)) return by_x;
        end
        return z;                            // Boxed in
    endfunction

    // ----------------------------------------
    // Model updates
    task automatic model_load(input zombie_arena_pkg::phase_t ph);
        m_phase = ph;
        m_health = 2'd3;
        m_shooter.x = 10'd320;
        m_shooter.y = 10'd224;
        for (int i = 0; i < 3; i++) begin
            m_zpos[i].x = 10'(z_spawn_x[i]);
            m_zpos[i].y = 10'(z_spawn_y[i]);
            m_alive[i] = 1'b0;
            m_cnt[i] = 0;
        end
    endtask

    task automatic model_frame();
        logic touch;
        zombie_arena_pkg::pos_t old_shooter;
        if (m_phase != zombie_arena_pkg::ph_playing) return;  // Idle and lost freeze all
        touch = 1'b0;
        old_shooter = m_shooter;
        for (int i = 0; i < 3; i++) begin
            if (m_alive[i] && absdiff(m_zpos[i].x, old_shooter.x) < 16 &&
                absdiff(m_zpos[i].y, old_shooter.y) < 16)
                touch = 1'b1;
        end
        for (int i = 0; i < 3; i++) begin
            if (m_alive[i])
                m_zpos[i] = ref_chase(m_zpos[i], old_shooter, z_speed[i], int'(level_sel));
            else if (m_cnt[i] == z_delay[i] - 1)
                m_alive[i] = 1'b1;           // Released, first step next tick
            else
                m_cnt[i]++;
        end
        m_shooter = ref_shooter_step(old_shooter, ref_move(keycode0, keycode1), int'(level_sel));
        if (touch) begin
            m_health = m_health - 2'd1;
            if (m_health == 2'd0) m_phase = zombie_arena_pkg::ph_lost;
        end
    endtask

    // ----------------------------------------
    // Compare
    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    always @(sample_ev) begin
        check("phase", 64'(phase), 64'(m_phase));
        check("health", 64'(health), 64'(m_health));
        check("shooter", 64'(shooter), 64'(m_shooter));
        for (int i = 0; i < 3; i++)
            check($sformatf("zombies[%0d]", i), 64'(zombies[i]), 64'({m_zpos[i], m_alive[i]}));
        compare_pending = 1'b0;
    end

    // ----------------------------------------
    // Stimulus tasks, all driven on falling edges
    task automatic sample_outputs();
        compare_pending = 1'b1;
        -> sample_ev;
        wait (!compare_pending);             // Compare pass finished
    endtask

    task automatic apply_reset();
        @(negedge Clk);
        reset = 1'b1;
        play = 1'b0;
        frame_tick = 1'b0;
        repeat (16) @(negedge Clk);
        reset = 1'b0;
        model_load(zombie_arena_pkg::ph_idle);
        @(negedge Clk);
        sample_outputs();
    endtask

    task automatic start_round();
        @(negedge Clk);
        play = 1'b1;
        @(negedge Clk);
        play = 1'b0;                         // round_start pulses now
        if (m_phase != zombie_arena_pkg::ph_playing) model_load(zombie_arena_pkg::ph_playing);
        @(negedge Clk);
        sample_outputs();
    endtask

    task automatic run_frame();
        @(negedge Clk);
        frame_tick = 1'b1;
        model_frame();                       // Same inputs the DUT sees at the tick
        @(negedge Clk);
        frame_tick = 1'b0;
        repeat (3) @(negedge Clk);
        sample_outputs();
    endtask

    task automatic set_keys(input logic [7:0] k0, input logic [7:0] k1);
        keycode0 = k0;
        keycode1 = k1;
    endtask

    task automatic set_random_keys();
        int r0;
        int r1;
        r0 = $urandom % 10;
        r1 = $urandom % 10;
        keycode0 = (r0 < 8) ? key_pool[r0] : 8'($urandom);  // Now and then any byte
        keycode1 = (r1 < 8) ? key_pool[r1] : 8'($urandom);
    endtask

    task automatic end_test(input string name);
        $display("%-24s %s, %0d errors", name, (n_errors == err_mark) ? "ok" : "mismatch",
                 n_errors - err_mark);
        err_mark = n_errors;
    endtask

    // ----------------------------------------
    // Test sequence
    initial begin
        int h_start;
        int drops;
        logic [1:0] h_prev;
        zombie_arena_pkg::pos_t frozen_shooter;
        zombie_arena_pkg::zombie_status_t [2:0] frozen_z;
        void'($urandom(5964));
        reset = 1'b1;
        play = 1'b0;
        frame_tick = 1'b0;
        level_sel = 2'd0;
        set_keys(8'h00, 8'h00);
        apply_reset();

        repeat (5) begin                     // Idle ticks move nothing
            set_random_keys();
            run_frame();
        end
        end_test("reset state");

        start_round();
        repeat (30) begin                    // Too short for any zombie to arrive
            set_random_keys();
            run_frame();
        end
        end_test("decode and stepping");

        for (int lvl = 0; lvl < 3; lvl++) begin
            apply_reset();
            level_sel = 2'(lvl);
            start_round();
            set_keys((lvl == 2) ? 8'h07 : 8'h04, 8'h00);
            repeat ((lvl == 0) ? 80 : 30) run_frame();
            // Left border, then right face of column 6, then left face of column 13
            check("shooter.x at wall", 64'(shooter.x), (lvl == 0) ? 64'd32 :
                  (lvl == 1) ? 64'd224 : 64'd412);
            if (lvl == 2) begin
                set_keys(8'h00, 8'h1A);      // Up into the top border
                repeat (60) run_frame();
            end
        end
        end_test("walls");

        apply_reset();
        level_sel = 2'd2;
        start_round();
        repeat (100) begin                   // Zombie 2 wakes on tick 60
            set_random_keys();
            run_frame();
        end
        end_test("chase and spawn delay");

        apply_reset();
        level_sel = 2'd0;                    // Open arena, every zombie can reach
        start_round();
        set_keys(8'h00, 8'h00);
        h_start = int'(health);
        drops = 0;
        for (int f = 0; f < 300 && phase != zombie_arena_pkg::ph_lost; f++) begin
            h_prev = health;
            run_frame();
            if (health != h_prev) drops++;
        end
        if (phase != zombie_arena_pkg::ph_lost) begin
            $display("Phase never reached lost while the shooter stood still");
            n_errors++;
        end
        check("health drops", 64'(drops), 64'(h_start));
        frozen_shooter = m_shooter;          // Model positions at the moment of loss
        for (int i = 0; i < 3; i++) begin
            frozen_z[i].pos = m_zpos[i];
            frozen_z[i].alive = m_alive[i];
        end
        repeat (10) begin
            set_random_keys();
            run_frame();
            check("frozen shooter", 64'(shooter), 64'(frozen_shooter));
            check("frozen zombies", 64'(zombies), 64'(frozen_z));
        end
        end_test("damage and loss");

        set_keys(8'h00, 8'h00);
        start_round();
        check("restart health", 64'(health), 64'd3);
        check("restart alive bits",
              64'({zombies[2].alive, zombies[1].alive, zombies[0].alive}), 64'd0);
        repeat (5) begin
            set_random_keys();
            run_frame();
        end
        end_test("restart");

        $display("checks run %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== zombie_arena.f ====
design/zombie_arena_pkg.sv
design/keycode_decoder.sv
design/barrier_map.sv
design/shooter_motion.sv
design/zombie_chaser.sv
design/game_state.sv
design/zombie_arena.sv
verification/zombie_arena_tb.sv
